// ==== verilog/sram_ctrl_params.svh ====
`ifndef SRAM_CTRL_PARAMS_SVH
`define SRAM_CTRL_PARAMS_SVH

// ====================
// First-layer feature map
// ====================
// Columns per map row
`define FMAP_COLS 6
`define FMAP_ROWS 4
// Channels carried side by side in every SRAM word
`define NUM_CH 4

// ====================
// Weights and SRAM addressing
// ====================
// Filters loaded before weights count as ready
`define NUM_FILT 4
`define FADDR_W 11
`define WADDR_W 5

`endif

// ==== verilog/sram_ctrl_pkg.sv ====
package sram_ctrl_pkg;

	// ====================
	// Control encodings
	// ====================
	// Layer sequencer phase
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_LOAD,
		PH_LOAD_READ,
		PH_READ
	} phase_t;

	// Code to the downstream data-process block
	typedef enum logic [2:0] {
		DP_IDLE       = 3'd0,
		DP_THREE_ZERO = 3'd1,
		DP_PAD_FWD    = 3'd2,
		DP_PAD_BWD    = 3'd3,
		DP_ONE_ZERO   = 3'd4,
		DP_FRONT      = 3'd5,
		DP_BACK       = 3'd6
	} dproc_t;

	// ====================
	// Payload types
	// ====================
	typedef logic [7:0] pixel_t;
	// Even pixel in the upper byte
	typedef logic [15:0] fword_t;
	typedef logic [23:0] wslice_t;
	// Three slices, first one on top
	typedef logic [71:0] wword_t;

endpackage

// ==== verilog/lane_packer.sv ====
`timescale 1ns/1ps
`include "sram_ctrl_params.svh"

module lane_packer #(
	parameter type slice_t = logic [7:0],
	parameter type word_t  = logic [15:0],
	parameter int  SLICES  = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 load,
	input  logic                 clear,
	input  slice_t [`NUM_CH-1:0] slices_in,
	output word_t  [`NUM_CH-1:0] words_out,
	output logic                 full
);

	localparam int CNT_W = (SLICES > 1) ? $clog2(SLICES) : 1;

	// Slices already taken into the current word
	logic [CNT_W-1:0] cnt;
	// Older slices of the word being built
	word_t [`NUM_CH-1:0] held;

	// ====================
	// Slice count
	// ====================
	// Last slice of a word arrives this cycle
	assign full = load && (cnt == CNT_W'(SLICES - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (clear) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= full ? '0 : cnt + 1'b1;
		end
	end

	// ====================
	// Per-channel shift
	// ====================
	// New slice enters at the bottom, top bits fall off
	always_comb begin
		for (int c = 0; c < `NUM_CH; c++) begin
			words_out[c] = word_t'({held[c], slices_in[c]});
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			held <= words_out;
		end
	end

endmodule

// ==== verilog/layer_sequencer.sv ====
`timescale 1ns/1ps

module layer_sequencer (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic pair_seen,
	input  logic load_done,
	output logic load_en,
	output logic read_en
);

	import sram_ctrl_pkg::*;

	phase_t phase;
	phase_t phase_nxt;

	// ====================
	// Phase transitions
	// ====================
	always_comb begin
		phase_nxt = phase;
		case (phase)
			PH_IDLE: begin
				phase_nxt = PH_LOAD;
			end
			PH_LOAD: begin
				// Two rows nearly in, reading may overlap loading
				if (pair_seen) begin
					phase_nxt = PH_LOAD_READ;
				end
			end
			PH_LOAD_READ: begin
				if (load_done) begin
					phase_nxt = PH_READ;
				end
			end
			default: begin
				phase_nxt = PH_READ;
			end
		endcase
	end

	// Start low forces idle on the next edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
		end else if (!start) begin
			phase <= PH_IDLE;
		end else begin
			phase <= phase_nxt;
		end
	end

	// ====================
	// Enable decode
	// ====================
	assign load_en = (phase == PH_LOAD) || (phase == PH_LOAD_READ);
	assign read_en = (phase == PH_LOAD_READ) || (phase == PH_READ);

endmodule

// ==== verilog/fmap_writer.sv ====
`timescale 1ns/1ps
`include "sram_ctrl_params.svh"

module fmap_writer (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 load_en,
	input  sram_ctrl_pkg::pixel_t [`NUM_CH-1:0]  data_in,
	output logic                                 cena_1,
	output logic                                 wena_1,
	output logic [`FADDR_W-1:0]                  aa_1,
	output sram_ctrl_pkg::fword_t [`NUM_CH-1:0]  da_1,
	output logic                                 pair_seen,
	output logic                                 load_done
);

	import sram_ctrl_pkg::*;

	localparam int NUM_PIX = `FMAP_ROWS * `FMAP_COLS;
	localparam int PIX_W = $clog2(NUM_PIX + 1);

	// Pixels consumed since loading began
	logic [PIX_W-1:0] pix_cnt;
	logic [`FADDR_W-1:0] addr;
	// Odd pixel of a pair present this cycle
	logic pair_full;

	// ====================
	// Pixel pairing
	// ====================
	lane_packer #(
		.slice_t(pixel_t),
		.word_t (fword_t),
		.SLICES (2)
	) u_pair_pack (
		.clk      (clk),
		.rst_n    (rst_n),
		.load     (load_en),
		.clear    (!load_en),
		.slices_in(data_in),
		.words_out(da_1),
		.full     (pair_full)
	);

	// ====================
	// Port A write
	// ====================
	// One write per pair, in the cycle of its odd pixel
	assign cena_1 = !pair_full;
	assign wena_1 = !pair_full;
	assign aa_1   = addr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr    <= '0;
			pix_cnt <= '0;
		end else if (!load_en) begin
			addr    <= '0;
			pix_cnt <= '0;
		end else begin
			pix_cnt <= pix_cnt + 1'b1;
			if (pair_full) begin
				addr <= addr + 1'b1;
			end
		end
	end

	// Progress pulses back to the sequencer
	assign pair_seen = load_en && (pix_cnt == PIX_W'(2 * `FMAP_COLS - 2));
	assign load_done = load_en && (pix_cnt == PIX_W'(NUM_PIX - 1));

endmodule

// ==== verilog/fmap_reader.sv ====
`timescale 1ns/1ps
`include "sram_ctrl_params.svh"

module fmap_reader (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  read_en,
	output logic                  cenb_1,
	output logic [`FADDR_W-1:0]   ab_1,
	output sram_ctrl_pkg::dproc_t data_process,
	output logic                  ccm_en,
	output logic                  ccm_en_cnt
);

	import sram_ctrl_pkg::*;

	localparam int COL_W = $clog2(`FMAP_COLS + 1);
	localparam logic [COL_W-1:0] LAST_COL = `FMAP_COLS;
	// Compute module starts counting three columns in
	localparam logic [COL_W-1:0] CNT_START_COL = 3;
	localparam logic [`FADDR_W-1:0] LAST_WORD = `FMAP_ROWS * `FMAP_COLS / 2 - 1;

	// Serpentine walk, B for backward rows and F for forward rows
	typedef enum logic [3:0] {
		S_IDLE,
		S_ZERO3,
		S_HEAD,
		S_TURN_B,
		S_B_FRONT,
		S_B_BACK,
		S_TURN,
		S_TURN_F,
		S_F_FRONT,
		S_F_BACK
	} rd_state_t;

	rd_state_t state;
	rd_state_t state_nxt;
	logic [COL_W-1:0] col;
	logic [COL_W-1:0] col_nxt;
	logic [`FADDR_W-1:0] addr;
	logic step;
	dproc_t code;

	// ====================
	// Walk decode
	// ====================
	always_comb begin
		state_nxt = state;
		col_nxt   = col;
		step      = 1'b0;
		code      = DP_IDLE;
		case (state)
			S_ZERO3: begin
				code      = DP_THREE_ZERO;
				state_nxt = (col == LAST_COL) ? S_TURN_B : S_HEAD;
			end
			S_HEAD: begin
				code      = DP_PAD_FWD;
				col_nxt   = col + 1'b1;
				// Word 0 is read twice, first time behind the zeros
				step      = (col != '0);
				state_nxt = (col_nxt == LAST_COL) ? S_ZERO3 : S_HEAD;
			end
			S_TURN_B: begin
				code      = DP_PAD_BWD;
				col_nxt   = LAST_COL;
				step      = 1'b1;
				state_nxt = S_B_FRONT;
			end
			S_B_FRONT: begin
				code      = DP_FRONT;
				col_nxt   = (col == LAST_COL) ? col - 2'd2 : col - 1'b1;
				step      = 1'b1;
				state_nxt = S_B_BACK;
			end
			S_B_BACK: begin
				code      = DP_BACK;
				col_nxt   = col - 1'b1;
				state_nxt = (col_nxt == COL_W'(1)) ? S_TURN : S_B_FRONT;
			end
			S_TURN: begin
				code = DP_ONE_ZERO;
				// Last word done, park until the next layer
				if (addr == LAST_WORD) begin
					state_nxt = S_IDLE;
				end else begin
					state_nxt = (col == COL_W'(1)) ? S_TURN_F : S_TURN_B;
				end
			end
			S_TURN_F: begin
				code      = DP_PAD_FWD;
				col_nxt   = COL_W'(1);
				step      = 1'b1;
				state_nxt = S_F_FRONT;
			end
			S_F_FRONT: begin
				code      = DP_FRONT;
				col_nxt   = (col == COL_W'(1)) ? col + 2'd2 : col + 1'b1;
				step      = 1'b1;
				state_nxt = S_F_BACK;
			end
			S_F_BACK: begin
				code      = DP_BACK;
				col_nxt   = col + 1'b1;
				state_nxt = (col_nxt == LAST_COL) ? S_TURN : S_F_FRONT;
			end
			default: begin
				state_nxt = S_IDLE;
			end
		endcase
		if (!read_en) begin
			code = DP_IDLE;
		end
	end

	// ====================
	// Port B strobe and address
	// ====================
	assign cenb_1 = !(read_en && (state != S_IDLE));
	assign ab_1   = step ? addr + 1'b1 : addr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_ZERO3;
			col   <= '0;
			addr  <= '0;
		end else if (!read_en) begin
			state <= S_ZERO3;
			col   <= '0;
			addr  <= '0;
		end else begin
			state <= state_nxt;
			col   <= col_nxt;
			addr  <= ab_1;
		end
	end

	// ====================
	// Downstream controls
	// ====================
	// Code lines up with the SRAM read data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_process <= DP_IDLE;
		end else begin
			data_process <= code;
		end
	end

	// Both enables are sticky until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ccm_en     <= 1'b0;
			ccm_en_cnt <= 1'b0;
		end else begin
			if (!cenb_1) begin
				ccm_en <= 1'b1;
			end
			if (read_en && (state == S_HEAD) && (col_nxt == CNT_START_COL)) begin
				ccm_en_cnt <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/weight_loader.sv ====
`timescale 1ns/1ps
`include "sram_ctrl_params.svh"

module weight_loader (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  load_en,
	input  sram_ctrl_pkg::wslice_t [`NUM_CH-1:0]  weight_in,
	output logic                                  cen_w,
	output logic                                  wen_w,
	output logic [`WADDR_W-1:0]                   a_w,
	output sram_ctrl_pkg::wword_t [`NUM_CH-1:0]   d_w,
	output logic                                  weight_en
);

	import sram_ctrl_pkg::*;

	localparam int FILT_W = $clog2(`NUM_FILT + 1);
	localparam int AW = `WADDR_W;

	// Filters already written, also the next word address
	logic [FILT_W-1:0] filt_cnt;
	// Slices accepted only until all filters are in
	logic packing;
	logic filt_full;

	assign packing = load_en && !weight_en;

	// ====================
	// Slice packing
	// ====================
	lane_packer #(
		.slice_t(wslice_t),
		.word_t (wword_t),
		.SLICES (3)
	) u_filt_pack (
		.clk      (clk),
		.rst_n    (rst_n),
		.load     (packing),
		.clear    (!load_en),
		.slices_in(weight_in),
		.words_out(d_w),
		.full     (filt_full)
	);

	// ====================
	// Weight SRAM write
	// ====================
	// Third slice of a filter writes the whole word
	assign cen_w = !filt_full;
	assign wen_w = !filt_full;
	assign a_w   = AW'(filt_cnt);

	// Kept across phases so the ready flag holds
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			filt_cnt <= '0;
		end else if (filt_full) begin
			filt_cnt <= filt_cnt + 1'b1;
		end
	end

	// All filters stored
	assign weight_en = (filt_cnt == FILT_W'(`NUM_FILT));

endmodule

// ==== verilog/sram_controller.sv ====
`timescale 1ns/1ps
`include "sram_ctrl_params.svh"

module sram_controller (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  start,
	input  sram_ctrl_pkg::pixel_t  [`NUM_CH-1:0]  data_in,
	input  sram_ctrl_pkg::wslice_t [`NUM_CH-1:0]  weight_in,
	// ====================
	// Feature SRAM port A
	// ====================
	output logic                                  cena_1,
	output logic                                  wena_1,
	output logic [`FADDR_W-1:0]                   aa_1,
	output sram_ctrl_pkg::fword_t  [`NUM_CH-1:0]  da_1,
	// Port B, read only
	output logic                                  cenb_1,
	output logic [`FADDR_W-1:0]                   ab_1,
	// ====================
	// Weight SRAM
	// ====================
	output logic                                  cen_w,
	output logic                                  wen_w,
	output logic [`WADDR_W-1:0]                   a_w,
	output sram_ctrl_pkg::wword_t  [`NUM_CH-1:0]  d_w,
	// Downstream data-process and compute controls
	output sram_ctrl_pkg::dproc_t                 data_process,
	output logic                                  ccm_en,
	output logic                                  ccm_en_cnt,
	output logic                                  weight_en
);

	// Phase enables and writer progress
	logic load_en;
	logic read_en;
	logic pair_seen;
	logic load_done;

	layer_sequencer u_seq (.*);

	fmap_writer u_writer (.*);

	fmap_reader u_reader (.*);

	weight_loader u_wload (.*);

endmodule

// ==== testbench/sram_controller_sva.sv ====
`timescale 1ns/1ps

module sram_controller_sva (
	input logic clk,
	input logic rst_n,
	input logic cena_1,
	input logic wena_1,
	input logic cenb_1,
	input logic cen_w,
	input logic wen_w,
	input logic ccm_en
);

	// Count of failed assertions
	int unsigned fail_cnt = 0;

	// ====================
	// Strobe legality
	// ====================
	// Write strobe needs its chip enable
	a_port_a_wen: assert property (@(posedge clk) disable iff (!rst_n)
		!wena_1 |-> !cena_1)
	else begin
		$error("Port A write enable low while its chip enable is high");
		fail_cnt++;
	end

	a_weight_wen: assert property (@(posedge clk) disable iff (!rst_n)
		!wen_w |-> !cen_w)
	else begin
		$error("Weight SRAM write enable low while its chip enable is high");
		fail_cnt++;
	end

	// Port B quiet while in reset
	a_port_b_reset: assert property (@(posedge clk) !rst_n |-> cenb_1)
	else begin
		$error("Port B chip enable low during reset");
		fail_cnt++;
	end

	// ====================
	// Compute start
	// ====================
	// Sticky once set
	a_ccm_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		ccm_en |=> ccm_en)
	else begin
		$error("ccm_en fell after it was set");
		fail_cnt++;
	end

endmodule

bind sram_controller sram_controller_sva u_sva (.*);

// ==== testbench/tb_sram_controller.sv ====
`timescale 1ns/1ps
`include "sram_ctrl_params.svh"

module tb_sram_controller;

	import sram_ctrl_pkg::*;

	localparam int NUM_LINES = `FMAP_ROWS * `FMAP_COLS;
	localparam int NUM_WORDS = NUM_LINES / 2;
	localparam int RESET_CYCLES = 16;
	// Four times the stimulus plus reset
	localparam int TIMEOUT_CYCLES = 4 * NUM_LINES + RESET_CYCLES;
	localparam int READ_MIN_PIX = 2 * `FMAP_COLS - 2;
	localparam logic [31:0] RAND_SEED = 32'h6bcac4a2;

	logic clk;
	logic rst_n;
	logic start;
	pixel_t [`NUM_CH-1:0] data_in;
	wslice_t [`NUM_CH-1:0] weight_in;
	logic cena_1;
	logic wena_1;
	logic [`FADDR_W-1:0] aa_1;
	fword_t [`NUM_CH-1:0] da_1;
	logic cenb_1;
	logic [`FADDR_W-1:0] ab_1;
	logic cen_w;
	logic wen_w;
	logic [`WADDR_W-1:0] a_w;
	wword_t [`NUM_CH-1:0] d_w;
	dproc_t data_process;
	logic ccm_en;
	logic ccm_en_cnt;
	logic weight_en;

	// Even entries hold pixels, odd entries weight slices
	logic [95:0] stim_mem [0:2*NUM_LINES-1];

	// Scoreboard state
	int lines_fed;
	int wr_cnt;
	int wt_cnt;
	int code_cnt;
	int cycle_cnt;
	logic read_seen;
	logic read_prev;
	int unsigned gap;

	sram_controller dut (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ====================
	// Helpers
	// ====================
	function automatic pixel_t pix_at(input int line, input int ch);
		logic [95:0] entry;
		entry = stim_mem[2 * line];
		return entry[8*ch +: 8];
	endfunction

	function automatic wslice_t slice_at(input int line, input int ch);
		logic [95:0] entry;
		entry = stim_mem[2 * line + 1];
		return entry[24*ch +: 24];
	endfunction

	task automatic expect_equal(input string name, input logic [95:0] expected,
			input logic [95:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %0h actual %0h", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "Run stopped at the first mismatch");
		end
	endtask

	// All SRAM strobes inactive, no code downstream
	task automatic check_strobes_idle(input string name);
		expect_equal({name, " cena_1"}, 1, cena_1);
		expect_equal({name, " wena_1"}, 1, wena_1);
		expect_equal({name, " cenb_1"}, 1, cenb_1);
		expect_equal({name, " cen_w"}, 1, cen_w);
		expect_equal({name, " wen_w"}, 1, wen_w);
		expect_equal({name, " data_process"}, DP_IDLE, data_process);
	endtask

	// ====================
	// Timeout
	// ====================
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("=== FAIL ===");
			$fatal(1, "Timeout, the reader never reached the last word within %0d cycles",
				TIMEOUT_CYCLES);
		end
	end

	// ====================
	// Output monitor
	// ====================
	always @(posedge clk) begin
		if (rst_n) begin
			// Code registered one cycle behind each read
			if (read_prev) begin
				expect_equal("code in range", 1,
					(data_process >= DP_THREE_ZERO) && (data_process <= DP_BACK));
				if (code_cnt == 0) begin
					expect_equal("first code", DP_THREE_ZERO, data_process);
				end else if (code_cnt == 1) begin
					expect_equal("second code", DP_PAD_FWD, data_process);
				end
				code_cnt++;
			end
			expect_equal("ccm_en after first read", read_seen, ccm_en);
			// Port B only reads words already written
			if (!cenb_1) begin
				// Line on data_in is still being taken in this cycle
				if (!read_seen) begin
					expect_equal("pixels before first read", 1,
						(lines_fed - 1) >= READ_MIN_PIX);
				end
				expect_equal("port B address below written", 1, ab_1 < wr_cnt);
				read_seen = 1'b1;
			end
			read_prev = !cenb_1;
			// Port A pixel pairs
			if (!cena_1) begin
				expect_equal("port A write count bound", 1, wr_cnt < NUM_WORDS);
				expect_equal("port A write enable", 0, wena_1);
				expect_equal("port A address", wr_cnt, aa_1);
				for (int c = 0; c < `NUM_CH; c++) begin
					expect_equal("port A data",
						{pix_at(2 * wr_cnt, c), pix_at(2 * wr_cnt + 1, c)}, da_1[c]);
				end
				wr_cnt++;
			end
			// Weight words, ready flag right after the last one
			expect_equal("weight_en", wt_cnt == `NUM_FILT, weight_en);
			if (!cen_w) begin
				expect_equal("weight write count bound", 1, wt_cnt < `NUM_FILT);
				expect_equal("weight write enable", 0, wen_w);
				expect_equal("weight address", wt_cnt, a_w);
				for (int c = 0; c < `NUM_CH; c++) begin
					expect_equal("weight data", {slice_at(3 * wt_cnt, c),
						slice_at(3 * wt_cnt + 1, c), slice_at(3 * wt_cnt + 2, c)}, d_w[c]);
				end
				wt_cnt++;
			end
		end
	end

	// ====================
	// Stimulus
	// ====================
	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		data_in = '0;
		weight_in = '0;
		lines_fed = 0;
		wr_cnt = 0;
		wt_cnt = 0;
		code_cnt = 0;
		cycle_cnt = 0;
		read_seen = 1'b0;
		read_prev = 1'b0;
		void'($urandom(RAND_SEED));
		$readmemh("testbench/stim_input.txt", stim_mem);
		expect_equal("stimulus file loaded", 0, $isunknown(stim_mem[2*NUM_LINES-1]));
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Random idle gap, nothing may move
		gap = 2 + ($urandom % 6);
		repeat (gap) begin
			@(posedge clk);
			check_strobes_idle("before start");
			expect_equal("before start ccm_en", 0, ccm_en);
			expect_equal("before start ccm_en_cnt", 0, ccm_en_cnt);
			expect_equal("before start weight_en", 0, weight_en);
		end
		@(negedge clk);
		start = 1'b1;
		// Loading begins one cycle after start
		for (int i = 0; i < NUM_LINES; i++) begin
			@(negedge clk);
			data_in = stim_mem[2 * i][31:0];
			weight_in = stim_mem[2 * i + 1];
			lines_fed = i + 1;
		end
		@(negedge clk);
		data_in = '0;
		weight_in = '0;
		// Reader still walking, on the last written word
		while (!(!cenb_1 && (ab_1 == NUM_WORDS - 1))) begin
			@(negedge clk);
		end
		expect_equal("port A write count", NUM_WORDS, wr_cnt);
		expect_equal("weight write count", `NUM_FILT, wt_cnt);
		expect_equal("ccm_en_cnt raised", 1, ccm_en_cnt);
		expect_equal("codes seen", 1, code_cnt >= 2);
		// Start low mid-read, phase idles on the next edge
		// and the code register one edge later
		start = 1'b0;
		repeat (3) @(posedge clk);
		check_strobes_idle("after start drop");
		expect_equal("assertion failures", 0, dut.u_sva.fail_cnt);
		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== testbench/stim_input.txt ====
// Column 1: pixels of channels 3..0, one byte each
// Column 2: weight slices of channels 3..0, 24 bits each
1a2b3c4d 0a0b0c1d1e1f2a2b2c3d3e3f
5e6f7081 4a4b4c5d5e5f6a6b6c7d7e7f
92a3b4c5 8a8b8c9d9e9faaabacbdbebf
d6e7f809 cacbccdddedfeaebecfdfeff
0f1e2d3c 102030405060708090a0b0c0
4b5a6978 d0e0f00111213141516171ff
8796a5b4 123456789abcdef012345678
c3d2e1f0 87654321fedcba9876543210
01234567 a5a5a55a5a5ac3c3c33c3c3c
89abcdef 0011223344556677889900aa
fedcba98 bbccddeeff00112233445566
76543210 778899aabbccddeeff001122
13579bdf 314159265358979323846264
2468ace0 271828182845904523536028
55aa33cc 141421356237309504880168
0ff0f00f 173205080756887729352744
9c8d7e6f deadbeefcafef00dbaadf00d
a1b2c3d4 0badc0de1badb0020d15ea5e
e5f60718 111111222222333333444444
293a4b5c 555555666666777777888888
6d7e8f90 999999aaaaaabbbbbbcccccc
b0c1d2e3 ddddddeeeeeeffffff000000
f4051627 123123456456789789abcabc
38495a6b fedfedcbacba987987654654

// ==== files.f ====
+incdir+verilog
verilog/sram_ctrl_pkg.sv
verilog/lane_packer.sv
verilog/layer_sequencer.sv
verilog/fmap_writer.sv
verilog/fmap_reader.sv
verilog/weight_loader.sv
verilog/sram_controller.sv
testbench/sram_controller_sva.sv
testbench/tb_sram_controller.sv
